// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = statusUnitTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
PASSMSG   = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: include/psr_settings.svh
`ifndef PSR_SETTINGS_SVH
`define PSR_SETTINGS_SVH

// wishbone word addresses of the host registers
`define ADDR_OPA     3'd0     // operand a
`define ADDR_OPB     3'd1     // operand b
`define ADDR_OP      3'd2     // opcode, a write here runs one execute step
`define ADDR_RESULT  3'd3     // data bus value of the last step, read only
`define ADDR_PSR     3'd4     // status word, read only

// psr bit positions, N V 1 B D I Z C from bit 7 down
`define PSR_C        0
`define PSR_Z        1
`define PSR_I        2
`define PSR_D        3
`define PSR_B        4
`define PSR_ONE      5        // unused bit, always reads one
`define PSR_V        6
`define PSR_N        7

`define PSR_RESET    8'h24    // I set, bit 5 set

`endif

// File: tests/statusUnitTb.sv
`timescale 1ns/1ns
`include "psr_settings.svh"

module statusUnitTb
    import cpuPkg::*;
();

    localparam int ClkPeriod    = 4;
    localparam int ResetCycles  = 16;
    localparam int CyclesPerVec = 40;   // budget for 5 bus transactions
    localparam int MaxVec       = 64;

    logic    clk, rst, cyc, stb, we;
    wbAddr   adr;
    dataByte datI, datO;
    logic    ack;
    psrWord  psr;

    logic [159:0] vecName [MaxVec];     // up to 20 characters
    logic [3:0]   vecOp   [MaxVec];
    dataByte      vecA    [MaxVec];
    dataByte      vecB    [MaxVec];
    dataByte      vecRes  [MaxVec];
    psrWord       vecPsr  [MaxVec];
    int           vecCount;
    logic         loaded;               // starts the watchdog
    logic         loadOk;
    int           resultErrors;
    int           psrErrors;
    dataByte      rdByte;

    statusUnitTop statusUnitTop_i (
        .clk (clk), .rst (rst), .cyc (cyc), .stb (stb), .we (we), .adr (adr),
        .datI (datI), .datO (datO), .ack (ack), .psr (psr)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    task automatic loadVectors(output logic ok);
        int           fd;
        int           n;
        logic [159:0] tok;
        logic [3:0]   op;
        dataByte      a, b, r;
        psrWord       p;
        logic [639:0] rest;
        fd = $fopen("tests/status_stim.txt", "r");
        vecCount = 0;
        if (fd != 0) begin
            while (!$feof(fd) && vecCount < MaxVec) begin
                n = $fscanf(fd, "%s %h %h %h %h %h\n", tok, op, a, b, r, p);
                if (n == 6) begin
                    vecName[vecCount] = tok;
                    vecOp[vecCount]   = op;
                    vecA[vecCount]    = a;
                    vecB[vecCount]    = b;
                    vecRes[vecCount]  = r;
                    vecPsr[vecCount]  = p;
                    vecCount++;
                end else if (n > 0) begin
                    n = $fgets(rest, fd);               // comment line, drop the rest
                end else begin
                    break;
                end
            end
            $fclose(fd);
        end
        ok = (fd != 0) && (vecCount > 0);
    endtask

    // request goes out on a falling edge, stb stays up over the edge that ends ack
    task automatic wbWrite(input wbAddr a, input dataByte d);
        @(negedge clk);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = 1'b1;
        adr  = a;
        datI = d;
        @(negedge clk);
        while (!ack) @(negedge clk);
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wbRead(input wbAddr a, output dataByte d);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        @(negedge clk);
        while (!ack) @(negedge clk);
        d = datO;                                   // stable while ack is high
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic checkByte(input logic [159:0] name, input dataByte exp, input dataByte act);
        if (act !== exp) begin
            $display("[FAIL] %0s result expected %02h actual %02h", name, exp, act);
            resultErrors++;
        end
    endtask

    task automatic checkPsr(input logic [159:0] name, input psrWord exp, input psrWord act);
        if (act !== exp) begin
            $display("[FAIL] %0s psr expected %02h actual %02h", name, exp, act);
            psrErrors++;
        end
    endtask

    task automatic runVector(input int i);
        dataByte res;
        psrWord  st;
        wbWrite(`ADDR_OPA, vecA[i]);
        wbWrite(`ADDR_OPB, vecB[i]);
        wbWrite(`ADDR_OP, {4'b0000, vecOp[i]});   // fires the execute step
        wbRead(`ADDR_RESULT, res);
        checkByte(vecName[i], vecRes[i], res);
        wbRead(`ADDR_PSR, st);
        checkPsr(vecName[i], vecPsr[i], st);
        checkPsr(vecName[i], vecPsr[i], psr);     // live status port, sampled on the falling edge
    endtask

    initial begin
        rst          = 1'b1;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        datI         = '0;
        loaded       = 1'b0;
        resultErrors = 0;
        psrErrors    = 0;
        loadVectors(loadOk);
        if (!loadOk) begin
            $display("could not read any vector from tests/status_stim.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (ResetCycles) @(negedge clk);
            rst = 1'b0;
            wbRead(`ADDR_PSR, rdByte);
            checkPsr("reset_psr", 8'h24, rdByte);   // I and bit 5 set
            checkPsr("reset_psr_port", 8'h24, psr);
            for (int i = 0; i < vecCount; i++) begin
                runVector(i);
            end
            $display("errors: result %0d, psr %0d over %0d vectors",
                     resultErrors, psrErrors, vecCount);
            if (resultErrors + psrErrors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

    // one extra slot for the reset read
    initial begin
        wait (loaded);
        repeat (ResetCycles + CyclesPerVec * (vecCount + 1)) @(posedge clk);
        $display("timeout, the vectors did not finish in time, a bus transaction got no ack");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: tests/statusUnit_chk.sv
`timescale 1ns/1ns
`include "psr_settings.svh"

module statusUnitChk import cpuPkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   cyc,
    input logic   stb,
    input logic   ack,
    input logic   exec,     // execute pulse inside the top level
    input psrWord psr
);

    // slave answers only a live request
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
        else $error("ack seen without cyc and stb");

    // classic handshake, one ack per request
    ackOneCycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack high for two cycles in a row");

    bitFiveSet: assert property (@(posedge clk) disable iff (rst) psr[`PSR_ONE])
        else $error("psr bit 5 reads zero");

    // flags move only on an execute step
    psrHolds: assert property (@(posedge clk) disable iff (rst) !exec |=> $stable(psr))
        else $error("psr changed without exec");

endmodule

bind statusUnitTop statusUnitChk statusUnitChk_i (
    .clk  (clk),
    .rst  (rst),
    .cyc  (cyc),
    .stb  (stb),
    .ack  (ack),
    .exec (exec),
    .psr  (psr)
);

// File: tests/status_stim.txt
// name, then op a b result psr in hex, one vector per line
// op codes as in cpuPkg: 0 ADC 1 SBC 2 AND 3 ORA 4 EOR 5 LDA 6 PLP 7 CLC 8 SEC 9 CLI a SEI b CLD c SED d CLV e BRK
adc_ovf        0 50 50 a0 e4
adc_carry_zero 0 ff 01 00 27
adc_carry_in   0 10 20 31 24
sec            8 5a 00 5a 25
sbc_no_borrow  1 50 30 20 25
sbc_borrow     1 30 50 e0 a4
sbc_ovf        1 80 01 7e 65
and_zero       2 f0 0f 00 67
ora_neg        3 80 01 81 e5
eor_zero       4 3c 3c 00 67
lda_neg        5 11 99 99 e5
lda_zero       5 77 00 00 67
sed            c 12 00 12 6f
cli            9 34 00 34 6b
clv            d 56 00 56 2b
clc            7 78 00 78 2a
sei            a 9a 00 9a 2e
cld            b bc 00 bc 26
brk            e de 00 de 36
plp_all        6 00 c3 c3 f3
plp_clear      6 ff 00 00 30
plp_id         6 00 0c 0c 3c
adc_binary     0 09 01 0a 3c
sbc_wrap       1 00 00 ff bc

// File: verilog/aluCore.sv
`timescale 1ns/1ns

module aluCore import cpuPkg::*; (
    input  opKind   opcode,
    input  dataByte opA,
    input  dataByte opB,
    input  logic    carryIn,    // C from the psr
    output dataByte dataBus,    // internal data bus value
    output logic    carryOut,
    output logic    overflow
);

    dataByte    addB;           // second adder input, inverted for SBC
    logic [8:0] sum;            // 9 bit so the carry falls out

    // binary only, D is not looked at
    assign addB = (opcode == SBC) ? ~opB : opB;
    assign sum  = {1'b0, opA} + {1'b0, addB} + {8'd0, carryIn};

    assign carryOut = sum[8];                       // for SBC this is not-borrow
    // signed overflow when both inputs share a sign the result does not
    assign overflow = (opA[7] == addB[7]) && (sum[7] != opA[7]);

    always_comb begin
        case (opcode)
            ADC, SBC: dataBus = sum[7:0];
            AND:      dataBus = opA & opB;
            ORA:      dataBus = opA | opB;
            EOR:      dataBus = opA ^ opB;
            LDA, PLP: dataBus = opB;        // loads drive b onto the bus
            default:  dataBus = opA;        // flag ops and BRK pass a
        endcase
    end

endmodule

// File: verilog/cpuPkg.sv
package cpuPkg;

    typedef logic [7:0] dataByte;   // one value on the internal data bus
    typedef logic [7:0] psrWord;    // status word N V 1 B D I Z C
    typedef logic [2:0] wbAddr;     // wishbone word address

    // operations of one execute step, 4 bit code as written by the host
    typedef enum logic [3:0] {
        ADC = 4'h0,                 // a + b + c
        SBC = 4'h1,                 // a + ~b + c, carry means no borrow
        AND = 4'h2,
        ORA = 4'h3,
        EOR = 4'h4,
        LDA = 4'h5,                 // load b, sets N and Z
        PLP = 4'h6,                 // pull flags from b
        CLC = 4'h7,
        SEC = 4'h8,
        CLI = 4'h9,
        SEI = 4'hA,
        CLD = 4'hB,
        SED = 4'hC,
        CLV = 4'hD,
        BRK = 4'hE                  // sets B and I
    } opKind;

    // code 4'hF is not an operation, it runs as a no-op step

endpackage

// File: verilog/flagCtrlIf.sv
`timescale 1ns/1ns

// per bit psr enables from the decoder to the status register
interface flagCtrlIf;

    logic load;                     // update strobe, one per execute step
    logic dbC, dbZ, dbI, dbD, dbV, dbN;   // take the bit from the data bus
    logic manC, manI, manD, manV;   // take manVal
    logic manVal;                   // value for manual set or clear
    logic carryC;                   // C from alu carry
    logic ovfV;                     // V from alu overflow
    logic dbAllZ;                   // Z from nor of the whole bus
    logic breakSet;                 // set B

    modport ctrl (
        output load,
        output dbC, dbZ, dbI, dbD, dbV, dbN,
        output manC, manI, manD, manV, manVal,
        output carryC, ovfV, dbAllZ, breakSet
    );

    modport flags (
        input load,
        input dbC, dbZ, dbI, dbD, dbV, dbN,
        input manC, manI, manD, manV, manVal,
        input carryC, ovfV, dbAllZ, breakSet
    );

endinterface

// File: verilog/flagDecoder.sv
`timescale 1ns/1ns

module flagDecoder import cpuPkg::*; (
    input  opKind         opcode,   // operation held by the host regs
    input  logic          exec,     // execute pulse
    flagCtrlIf.ctrl       ctrl      // enables to the status register
);

    // random control logic, every enable is qualified by exec
    always_comb begin
        ctrl.load     = exec;
        ctrl.dbC      = 1'b0;
        ctrl.dbZ      = 1'b0;
        ctrl.dbI      = 1'b0;
        ctrl.dbD      = 1'b0;
        ctrl.dbV      = 1'b0;
        ctrl.dbN      = 1'b0;
        ctrl.manC     = 1'b0;
        ctrl.manI     = 1'b0;
        ctrl.manD     = 1'b0;
        ctrl.manV     = 1'b0;
        ctrl.manVal   = 1'b0;
        ctrl.carryC   = 1'b0;
        ctrl.ovfV     = 1'b0;
        ctrl.dbAllZ   = 1'b0;
        ctrl.breakSet = 1'b0;
        if (exec) begin
            case (opcode)
                ADC, SBC: begin
                    ctrl.carryC = 1'b1;     // C and V from the adder
                    ctrl.ovfV   = 1'b1;
                    ctrl.dbN    = 1'b1;     // N is bus bit 7
                    ctrl.dbAllZ = 1'b1;
                end
                AND, ORA, EOR, LDA: begin
                    ctrl.dbN    = 1'b1;     // only N and Z move
                    ctrl.dbAllZ = 1'b1;
                end
                PLP: begin
                    ctrl.dbC = 1'b1;        // every flag from the bus except B
                    ctrl.dbZ = 1'b1;
                    ctrl.dbI = 1'b1;
                    ctrl.dbD = 1'b1;
                    ctrl.dbV = 1'b1;
                    ctrl.dbN = 1'b1;
                end
                CLC: ctrl.manC = 1'b1;
                SEC: begin
                    ctrl.manC   = 1'b1;
                    ctrl.manVal = 1'b1;
                end
                CLI: ctrl.manI = 1'b1;
                SEI: begin
                    ctrl.manI   = 1'b1;
                    ctrl.manVal = 1'b1;
                end
                CLD: ctrl.manD = 1'b1;
                SED: begin
                    ctrl.manD   = 1'b1;
                    ctrl.manVal = 1'b1;
                end
                CLV: ctrl.manV = 1'b1;      // no SEV on a 6502
                BRK: begin
                    ctrl.breakSet = 1'b1;
                    ctrl.manI     = 1'b1;   // mask further irqs
                    ctrl.manVal   = 1'b1;
                end
                default: ;                  // spare code, flags hold
            endcase
        end
    end

endmodule

// File: verilog/processStatusReg.sv
`timescale 1ns/1ns
`include "psr_settings.svh"

module processStatusReg import cpuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  dataByte   dataBus,      // internal bus
    input  logic      carry,        // alu carry out
    input  logic      overflow,     // alu overflow
    flagCtrlIf.flags  flags,        // enables from the decoder
    output psrWord    psr
);

    localparam psrWord ResetVal = `PSR_RESET;

    logic   flagC, flagZ, flagI, flagD, flagB, flagV, flagN;

    always_ff @(posedge clk) begin
        if (rst) begin
            flagC <= ResetVal[`PSR_C];
            flagZ <= ResetVal[`PSR_Z];
            flagI <= ResetVal[`PSR_I];
            flagD <= ResetVal[`PSR_D];
            flagB <= ResetVal[`PSR_B];
            flagV <= ResetVal[`PSR_V];
            flagN <= ResetVal[`PSR_N];
        end else if (flags.load) begin
            // each bit picks its own source, no enable keeps the old value
            if (flags.dbC)         flagC <= dataBus[`PSR_C];
            else if (flags.carryC) flagC <= carry;
            else if (flags.manC)   flagC <= flags.manVal;

            if (flags.dbZ)         flagZ <= dataBus[`PSR_Z];
            else if (flags.dbAllZ) flagZ <= ~|dataBus;      // zero detect

            if (flags.dbI)         flagI <= dataBus[`PSR_I];
            else if (flags.manI)   flagI <= flags.manVal;

            if (flags.dbD)         flagD <= dataBus[`PSR_D];
            else if (flags.manD)   flagD <= flags.manVal;

            if (flags.breakSet)    flagB <= 1'b1;           // only reset clears B

            if (flags.dbV)         flagV <= dataBus[`PSR_V];
            else if (flags.ovfV)   flagV <= overflow;
            else if (flags.manV)   flagV <= flags.manVal;

            if (flags.dbN)         flagN <= dataBus[`PSR_N];
        end
    end

    always_comb begin
        psr           = '0;
        psr[`PSR_C]   = flagC;
        psr[`PSR_Z]   = flagZ;
        psr[`PSR_I]   = flagI;
        psr[`PSR_D]   = flagD;
        psr[`PSR_B]   = flagB;
        psr[`PSR_ONE] = 1'b1;       // no flip-flop behind bit 5
        psr[`PSR_V]   = flagV;
        psr[`PSR_N]   = flagN;
    end

endmodule

// File: verilog/statusUnitTop.sv
`timescale 1ns/1ns
`include "psr_settings.svh"

module statusUnitTop import cpuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  wbAddr   adr,
    input  dataByte datI,
    output dataByte datO,
    output logic    ack,
    output psrWord  psr         // live status, also readable over the bus
);

    dataByte opA, opB;
    opKind   opcode;
    logic    exec;
    dataByte dataBus;
    logic    carryOut, overflow;

    flagCtrlIf flagBus ();      // decoder to status register

    wbHostRegs wbHostRegs_i (
        .clk     (clk),
        .rst     (rst),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .datI    (datI),
        .datO    (datO),
        .ack     (ack),
        .opA     (opA),
        .opB     (opB),
        .opcode  (opcode),
        .exec    (exec),
        .dataBus (dataBus),
        .psr     (psr)
    );

    flagDecoder flagDecoder_i (
        .opcode (opcode),
        .exec   (exec),
        .ctrl   (flagBus)
    );

    aluCore aluCore_i (
        .opcode   (opcode),
        .opA      (opA),
        .opB      (opB),
        .carryIn  (psr[`PSR_C]),    // carry chain through the psr
        .dataBus  (dataBus),
        .carryOut (carryOut),
        .overflow (overflow)
    );

    processStatusReg processStatusReg_i (
        .clk      (clk),
        .rst      (rst),
        .dataBus  (dataBus),
        .carry    (carryOut),
        .overflow (overflow),
        .flags    (flagBus),
        .psr      (psr)
    );

endmodule

// File: verilog/wbHostRegs.sv
`timescale 1ns/1ns
`include "psr_settings.svh"

module wbHostRegs import cpuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  wbAddr   adr,
    input  dataByte datI,
    output dataByte datO,
    output logic    ack,
    output dataByte opA,        // operand a to the alu
    output dataByte opB,        // operand b to the alu
    output opKind   opcode,     // operation of the execute step
    output logic    exec,       // one cycle execute pulse
    input  dataByte dataBus,    // alu bus value, captured on exec
    input  psrWord  psr         // status word for readback
);

    logic    accept;            // request sampled on this edge
    logic    wrAccept;
    logic    rdAccept;
    dataByte result;            // last data bus value
    dataByte rdData;            // read mux output

    // a new request is taken only while no ack is out, so ack lasts one cycle
    assign accept   = cyc & stb & ~ack;
    assign wrAccept = accept & we;
    assign rdAccept = accept & ~we;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack  <= 1'b0;
            exec <= 1'b0;
        end else begin
            ack  <= accept;                             // registered, one cycle late
            exec <= wrAccept && (adr == `ADDR_OP);      // fires once per opcode write
        end
    end

    // host visible registers
    always_ff @(posedge clk) begin
        if (rst) begin
            opA    <= '0;
            opB    <= '0;
            opcode <= CLC;
        end else if (wrAccept) begin
            case (adr)
                `ADDR_OPA: opA    <= datI;
                `ADDR_OPB: opB    <= datI;
                `ADDR_OP:  opcode <= opKind'(datI[3:0]);   // upper nibble dropped
                default: ;                                // result and psr are read only
            endcase
        end
    end

    // result follows the bus on the execute step, same edge as the psr
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (exec) begin
            result <= dataBus;
        end
    end

    always_comb begin
        case (adr)
            `ADDR_OPA:    rdData = opA;
            `ADDR_OPB:    rdData = opB;
            `ADDR_OP:     rdData = {4'b0000, opcode};
            `ADDR_RESULT: rdData = result;
            `ADDR_PSR:    rdData = psr;
            default:      rdData = '0;    // unmapped
        endcase
    end

    // read data is sampled with the request and held while ack is high
    always_ff @(posedge clk) begin
        if (rdAccept) begin
            datO <= rdData;
        end
    end

endmodule

// File: vlog.f
+incdir+include
verilog/cpuPkg.sv
verilog/flagCtrlIf.sv
verilog/wbHostRegs.sv
verilog/flagDecoder.sv
verilog/aluCore.sv
verilog/processStatusReg.sv
verilog/statusUnitTop.sv
tests/statusUnit_chk.sv
tests/statusUnitTb.sv
